//--- tb.f
+incdir+tests
design/mips_pkg.sv
design/fetch_unit.sv
design/control_decoder.sv
design/register_file.sv
design/alu.sv
design/load_align.sv
design/bus_master.sv
design/mips_cpu_bus.sv
tests/tb_mips_cpu_bus.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_mips_cpu_bus
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' tb.f)
HEADERS := $(wildcard tests/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): tb.f $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f tb.f

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'PASS: all tests'

clean:
	rm -rf $(BUILD_DIR)

//--- tests/tb_mips_model.svh
/*
 * Instruction-set reference model, memory fill and byte-lane helpers,
 * random program generator
 */
`ifndef TB_MIPS_MODEL_SVH
`define TB_MIPS_MODEL_SVH

function automatic logic [31:0] mem_fill(logic [31:0] addr);
	return (addr * 32'h9E3779B1) ^ (addr >> 5) ^ 32'h5A3C96E1;
endfunction

function automatic logic [31:0] be_mask(logic [3:0] be);
	return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
endfunction

function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] data, logic [3:0] be);
	return (old & ~be_mask(be)) | (data & be_mask(be));
endfunction

function automatic logic [31:0] ref_read(logic [31:0] addr);
	return ref_mem.exists(addr) ? ref_mem[addr] : mem_fill(addr);
endfunction

// Runs the program in ref_mem with delay slots until the jump to zero
function automatic void run_reference();
	logic [31:0] regs [32];
	logic [31:0] pc, npc, pc4, tgt, w, a, b, res, ea, simm, zimm, wa;
	logic [4:0] rs, rt, rd, sh, dst;
	logic [5:0] op, fn;
	logic [7:0] bsel;
	logic [3:0] be;
	logic wr;
	int k;
	int steps;
	store_t st;
	for (int i = 0; i < 32; i++)
		regs[i] = '0;
	pc = mips_pkg::reset_vector;
	npc = pc + 32'd4;
	steps = 0;
	while (pc != mips_pkg::halt_address && steps < 4000) begin
		w = ref_read(pc);
		pc4 = pc + 32'd4;
		op = w[31:26];
		rs = w[25:21];
		rt = w[20:16];
		rd = w[15:11];
		sh = w[10:6];
		fn = w[5:0];
		simm = {{16{w[15]}}, w[15:0]};
		zimm = {16'h0000, w[15:0]};
		a = regs[rs];
		b = regs[rt];
		tgt = npc + 32'd4;
		wr = 1'b0;
		dst = rt;
		res = '0;
		ea = a + simm;
		wa = {ea[31:2], 2'b00};
		k = int'(ea[1:0]);
		case (op)
			mips_pkg::op_special: begin
				wr = 1'b1;
				dst = rd;
				case (fn)
					mips_pkg::fn_addu: res = a + b;
					mips_pkg::fn_subu: res = a - b;
					mips_pkg::fn_and: res = a & b;
					mips_pkg::fn_or: res = a | b;
					mips_pkg::fn_xor: res = a ^ b;
					mips_pkg::fn_slt: res = {31'b0, $signed(a) < $signed(b)};
					mips_pkg::fn_sltu: res = {31'b0, a < b};
					mips_pkg::fn_sll: res = b << sh;
					mips_pkg::fn_srl: res = b >> sh;
					mips_pkg::fn_jr: begin
						wr = 1'b0;
						tgt = a;
					end
					default: wr = 1'b0;
				endcase
			end
			mips_pkg::op_addiu: {wr, res} = {1'b1, a + simm};
			mips_pkg::op_slti: {wr, res} = {1'b1, 31'b0, $signed(a) < $signed(simm)};
			mips_pkg::op_andi: {wr, res} = {1'b1, a & zimm};
			mips_pkg::op_ori: {wr, res} = {1'b1, a | zimm};
			mips_pkg::op_xori: {wr, res} = {1'b1, a ^ zimm};
			mips_pkg::op_lui: {wr, res} = {1'b1, w[15:0], 16'h0000};
			mips_pkg::op_lw: {wr, res} = {1'b1, ref_read(wa)};
			mips_pkg::op_lb, mips_pkg::op_lbu: begin
				bsel = 8'(ref_read(wa) >> (8 * k));
				wr = 1'b1;
				res = (op == mips_pkg::op_lb) ? {{24{bsel[7]}}, bsel} : {24'h0, bsel};
			end
			mips_pkg::op_sw, mips_pkg::op_sb: begin
				be = (op == mips_pkg::op_sw) ? 4'b1111 : (4'b0001 << ea[1:0]);
				st.addr = wa;
				st.be = be;
				st.data = ((op == mips_pkg::op_sw) ? b : {4{b[7:0]}}) & be_mask(be);
				exp_stores.push_back(st);
				ref_mem[wa] = merge_bytes(ref_read(wa), st.data, be);
			end
			mips_pkg::op_beq: if (a == b) tgt = pc4 + (simm << 2);
			mips_pkg::op_bne: if (a != b) tgt = pc4 + (simm << 2);
			mips_pkg::op_j: tgt = {pc4[31:28], w[25:0], 2'b00};
			default: ;
		endcase
		if (wr && dst != 5'd0)
			regs[dst] = res;
		pc = npc;
		npc = tgt;
		steps++;
	end
	exp_v0 = regs[2];
endfunction

function automatic logic [31:0] enc_r(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
		logic [4:0] sh, logic [5:0] fn);
	return {mips_pkg::op_special, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic logic [4:0] any_reg();
	return 5'($urandom % 16);
endfunction

function automatic logic [4:0] dest_reg();
	return 5'(1 + $urandom % 15);
endfunction
`endif

//--- tests/tb_mips_cpu_bus.sv
/*
 * Testbench for mips_cpu_bus with clock, reset, random program,
 * Avalon memory model, store comparator and watchdog
 */
`timescale 1ns/1ps

module tb_mips_cpu_bus;

	typedef struct packed {
		logic [31:0] addr;
		logic [3:0] be;
		logic [31:0] data;
	} store_t;

	logic clk = 1'b0;
	logic rst_n;
	logic active;
	logic [31:0] register_v0;
	logic [31:0] address;
	logic write;
	logic read;
	logic waitrequest;
	logic [31:0] writedata;
	logic [3:0] byteenable;
	logic [31:0] readdata;

	logic [31:0] mem [logic [31:0]];
	logic [31:0] ref_mem [logic [31:0]];
	store_t exp_stores [$];
	store_t got_stores [$];
	logic [31:0] exp_v0;
	int prog_len = 0;
	int errors = 0;
	int stores_checked = 0;

	logic pending = 1'b0;
	logic [31:0] held_addr;
	logic [31:0] held_wdata;
	logic [3:0] held_be;
	logic held_write;

	`include "tb_mips_model.svh"

	mips_cpu_bus UUT (
		.clk(clk), .rst_n(rst_n), .active(active), .register_v0(register_v0),
		.address(address), .write(write), .read(read), .waitrequest(waitrequest),
		.writedata(writedata), .byteenable(byteenable), .readdata(readdata)
	);

	task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	function automatic logic [31:0] mem_read(logic [31:0] addr);
		return mem.exists(addr) ? mem[addr] : mem_fill(addr);
	endfunction

	// n random instructions after the base setup followed by JR $0 and a no-op
	function automatic void build_program(int n);
		logic [5:0] fns [9];
		logic [5:0] iops [6];
		logic [5:0] op;
		logic [5:0] fn;
		logic [31:0] w;
		logic [31:0] tgt;
		logic [15:0] off;
		int kind;
		int was_branch;
		fns = '{mips_pkg::fn_addu, mips_pkg::fn_subu, mips_pkg::fn_and, mips_pkg::fn_or,
			mips_pkg::fn_xor, mips_pkg::fn_slt, mips_pkg::fn_sltu, mips_pkg::fn_sll,
			mips_pkg::fn_srl};
		iops = '{mips_pkg::op_addiu, mips_pkg::op_slti, mips_pkg::op_andi,
			mips_pkg::op_ori, mips_pkg::op_xori, mips_pkg::op_lui};
		was_branch = 0;
		mem[mips_pkg::reset_vector] = enc_i(mips_pkg::op_addiu, 5'd0, 5'd28, 16'h1000);
		for (int i = 1; i <= n; i++) begin
			kind = int'($urandom % 10);
			if (kind >= 8 && (was_branch != 0 || i > n - 5))
				kind = 3; // No branch in a delay slot or near the end
			case (kind)
				0, 1, 2: begin
					fn = fns[$urandom % 9];
					w = enc_r(any_reg(), any_reg(), dest_reg(),
						(fn == mips_pkg::fn_sll || fn == mips_pkg::fn_srl) ?
						5'($urandom % 32) : 5'd0, fn);
				end
				3, 4: w = enc_i(iops[$urandom % 6], any_reg(), dest_reg(), 16'($urandom));
				5: begin
					op = (($urandom % 3) == 0) ? mips_pkg::op_lw :
						((($urandom % 2) == 0) ? mips_pkg::op_lb : mips_pkg::op_lbu);
					off = (op == mips_pkg::op_lw) ? 16'(4 * ($urandom % 16)) :
						16'($urandom % 64);
					w = enc_i(op, 5'd28, dest_reg(), off);
				end
				6, 7: begin
					op = (kind == 6) ? mips_pkg::op_sw : mips_pkg::op_sb;
					off = (op == mips_pkg::op_sw) ? 16'(4 * ($urandom % 16)) :
						16'($urandom % 64);
					w = enc_i(op, 5'd28, any_reg(), off);
				end
				8: begin
					op = (($urandom % 2) == 0) ? mips_pkg::op_beq : mips_pkg::op_bne;
					w = enc_i(op, any_reg(), any_reg(), 16'(1 + $urandom % 3));
				end
				default: begin
					tgt = mips_pkg::reset_vector + 32'(4 * (i + 2 + int'($urandom % 3)));
					w = {mips_pkg::op_j, tgt[27:2]};
				end
			endcase
			mem[mips_pkg::reset_vector + 32'(4 * i)] = w;
			was_branch = (kind >= 8) ? 1 : 0;
		end
		mem[mips_pkg::reset_vector + 32'(4 * (n + 1))] =
			enc_r(5'd0, 5'd0, 5'd0, 5'd0, mips_pkg::fn_jr);
		mem[mips_pkg::reset_vector + 32'(4 * (n + 2))] = 32'h00000000;
		prog_len = n + 3;
	endfunction

	initial begin
		forever #10 clk = ~clk;
	end

	// Avalon slave, bus rule monitor and write capture
	always @(negedge clk) begin
		store_t st;
		if (rst_n) begin
			if (pending) begin
				check_value("held address", address, held_addr);
				check_value("held byteenable", {28'h0, byteenable}, {28'h0, held_be});
				if (held_write)
					check_value("held writedata", writedata, held_wdata);
			end
			if (read && write) begin
				errors++;
				$display("read and write are both high at %0t", $time);
			end
			if (!active && (read || write)) begin
				errors++;
				$display("bus transfer started after halt at %0t", $time);
			end
			waitrequest = (($urandom % 3) == 0);
			readdata = mem_read(address);
			if (write && !waitrequest) begin
				st.addr = address;
				st.be = byteenable;
				st.data = writedata & be_mask(byteenable);
				mem[address] = merge_bytes(mem_read(address), writedata, byteenable);
				got_stores.push_back(st);
			end
			pending = (read || write) && waitrequest;
			held_addr = address;
			held_wdata = writedata;
			held_be = byteenable;
			held_write = write;
		end
	end

	// Store comparator in program order
	always @(posedge clk) begin
		store_t got;
		store_t exp;
		while (got_stores.size() > 0) begin
			got = got_stores.pop_front();
			if (exp_stores.size() == 0) begin
				errors++;
				$display("unexpected store to %h at %0t", got.addr, $time);
			end else begin
				exp = exp_stores.pop_front();
				check_value("store address", got.addr, exp.addr);
				check_value("store byteenable", {28'h0, got.be}, {28'h0, exp.be});
				check_value("store data", got.data, exp.data);
				stores_checked++;
			end
		end
	end

	initial begin
		wait (prog_len > 0);
		repeat (prog_len * 40) @(posedge clk);
		$display("timeout: core did not halt within %0d cycles", prog_len * 40);
		$display("stores checked %0d, errors %0d", stores_checked, errors + 1);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		waitrequest = 1'b0;
		readdata = '0;
		void'($urandom(45401));
		build_program(60);
		ref_mem = mem;
		run_reference();
		repeat (5) @(negedge clk);
		rst_n <= 1'b1;
		while (active)
			@(negedge clk);
		repeat (20) @(negedge clk); // Bus must stay quiet after halt
		check_value("register_v0", register_v0, exp_v0);
		if (exp_stores.size() != 0) begin
			errors++;
			$display("%0d expected stores never appeared on the bus", exp_stores.size());
		end
		$display("stores checked %0d, errors %0d", stores_checked, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- design/mips_cpu_bus.sv
/* MIPS core top level with one Avalon-MM master port */
`timescale 1ns/1ps

module mips_cpu_bus (
	input logic clk,
	input logic rst_n,
	output logic active,
	output logic [31:0] register_v0,
	output logic [31:0] address,
	output logic write,
	output logic read,
	input logic waitrequest,
	output logic [31:0] writedata,
	output logic [3:0] byteenable,
	input logic [31:0] readdata
);

	mips_pkg::instr_t instr;
	mips_pkg::ctrl_t ctrl;
	mips_pkg::mem_req_t req;

	logic [mips_pkg::word_w-1:0] pc;
	logic halted;
	logic step_done;
	logic [mips_pkg::word_w-1:0] rs_value;
	logic [mips_pkg::word_w-1:0] rt_value;
	logic [mips_pkg::word_w-1:0] imm_ext;
	logic [mips_pkg::word_w-1:0] alu_a;
	logic [mips_pkg::word_w-1:0] alu_b;
	logic [mips_pkg::word_w-1:0] alu_y;
	logic [mips_pkg::word_w-1:0] load_data;
	logic [mips_pkg::word_w-1:0] load_value;
	logic [mips_pkg::word_w-1:0] wb_data;
	logic [mips_pkg::reg_addr_w-1:0] wr_addr;
	logic is_load;

	// Input side
	fetch_unit u_fetch (
		.clk(clk), .rst_n(rst_n), .instr(instr), .ctrl(ctrl),
		.rs_value(rs_value), .rt_value(rt_value), .step_done(step_done),
		.pc(pc), .halted(halted)
	);

	// Processing
	control_decoder u_decode (.instr(instr), .ctrl(ctrl));

	register_file u_regs (
		.clk(clk), .rst_n(rst_n), .rs_addr(instr.rs), .rt_addr(instr.rt),
		.wr_addr(wr_addr), .wr_en(step_done && ctrl.reg_write), .wr_data(wb_data),
		.rs_data(rs_value), .rt_data(rt_value), .v0(register_v0)
	);

	assign imm_ext = ctrl.imm_zero_extend ? {16'h0000, instr.low.imm} :
		{{16{instr.low.imm[15]}}, instr.low.imm};
	assign alu_a = ctrl.shift_by_shamt ? rt_value : rs_value; // Shifts act on rt
	assign alu_b = ctrl.src_b_imm ? imm_ext : rt_value;

	alu u_alu (.op(ctrl.alu_op), .a(alu_a), .b(alu_b), .shamt(instr.low.r.shamt), .y(alu_y));

	assign req = '{addr: alu_y, wdata: rt_value, mem_kind: ctrl.mem_kind};

	// Output side
	bus_master u_bus (
		.clk(clk), .rst_n(rst_n), .pc(pc), .halted(halted), .req(req),
		.address(address), .writedata(writedata), .byteenable(byteenable),
		.read(read), .write(write), .waitrequest(waitrequest), .readdata(readdata),
		.instr(instr), .load_data(load_data), .step_done(step_done)
	);

	load_align u_align (
		.kind(ctrl.mem_kind), .byte_sel(alu_y[1:0]), .raw(load_data), .value(load_value)
	);

	assign is_load = (ctrl.mem_kind == mips_pkg::mem_lw) ||
		(ctrl.mem_kind == mips_pkg::mem_lb) || (ctrl.mem_kind == mips_pkg::mem_lbu);
	assign wb_data = is_load ? load_value : alu_y;
	assign wr_addr = ctrl.dest_rd ? instr.low.r.rd : instr.rt;

	assign active = !halted;

endmodule

//--- design/bus_master.sv
/*
 * Avalon-MM sequencer for fetch and data phases,
 * address and byteenable generation, instruction latch
 */
`timescale 1ns/1ps

module bus_master (
	input logic clk,
	input logic rst_n,
	input logic [mips_pkg::word_w-1:0] pc,
	input logic halted,
	input mips_pkg::mem_req_t req,
	output logic [mips_pkg::word_w-1:0] address,
	output logic [mips_pkg::word_w-1:0] writedata,
	output logic [3:0] byteenable,
	output logic read,
	output logic write,
	input logic waitrequest,
	input logic [mips_pkg::word_w-1:0] readdata,
	output mips_pkg::instr_t instr,
	output logic [mips_pkg::word_w-1:0] load_data,
	output logic step_done
);

	typedef enum logic [1:0] {st_idle, st_fetch, st_exec, st_data} state_t;

	state_t state;
	logic is_load;
	logic is_store;
	logic is_byte;
	logic has_mem;
	logic fetch_req_done;

	assign is_load = (req.mem_kind == mips_pkg::mem_lw) ||
		(req.mem_kind == mips_pkg::mem_lb) || (req.mem_kind == mips_pkg::mem_lbu);
	assign is_store = (req.mem_kind == mips_pkg::mem_sw) || (req.mem_kind == mips_pkg::mem_sb);
	assign is_byte = (req.mem_kind == mips_pkg::mem_lb) ||
		(req.mem_kind == mips_pkg::mem_lbu) || (req.mem_kind == mips_pkg::mem_sb);
	assign has_mem = is_load || is_store;

	// No fetch is issued once the core has halted
	assign read = ((state == st_fetch) && !halted) || ((state == st_data) && is_load);
	assign write = (state == st_data) && is_store;
	assign fetch_req_done = (state == st_fetch) && read && !waitrequest;

	assign step_done = ((state == st_exec) && !has_mem) ||
		((state == st_data) && !waitrequest);
	assign load_data = readdata; // Sampled by the register file on step_done

	always_comb begin
		if (state == st_data) begin
			address = {req.addr[31:2], 2'b00};
			byteenable = is_byte ? (4'b0001 << req.addr[1:0]) : 4'b1111;
		end else begin
			address = {pc[31:2], 2'b00};
			byteenable = 4'b1111;
		end
		// Byte stores go out on every lane
		writedata = (req.mem_kind == mips_pkg::mem_sb) ? {4{req.wdata[7:0]}} : req.wdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:
					if (!halted)
						state <= st_fetch;
				st_fetch:
					if (halted)
						state <= st_idle;
					else if (fetch_req_done)
						state <= st_exec;
				st_exec:
					state <= has_mem ? st_data : st_fetch;
				st_data:
					if (!waitrequest)
						state <= st_fetch;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			instr <= '0;
		else if (fetch_req_done)
			instr <= readdata;
	end

endmodule

//--- design/load_align.sv
/* Load lane select with sign or zero extension */
`timescale 1ns/1ps

module load_align (
	input mips_pkg::mem_kind_t kind,
	input logic [1:0] byte_sel,
	input logic [mips_pkg::word_w-1:0] raw,
	output logic [mips_pkg::word_w-1:0] value
);

	logic [7:0] lane;

	// Lane 0 is the low byte
	always_comb begin
		case (byte_sel)
			2'd0: lane = raw[7:0];
			2'd1: lane = raw[15:8];
			2'd2: lane = raw[23:16];
			default: lane = raw[31:24];
		endcase
	end

	always_comb begin
		case (kind)
			mips_pkg::mem_lb: value = {{24{lane[7]}}, lane};
			mips_pkg::mem_lbu: value = {24'h000000, lane};
			default: value = raw; // Word load
		endcase
	end

endmodule

//--- design/alu.sv
/* Add, subtract, logic, compare and shift unit */
`timescale 1ns/1ps

module alu (
	input mips_pkg::alu_op_t op,
	input logic [mips_pkg::word_w-1:0] a,
	input logic [mips_pkg::word_w-1:0] b,
	input logic [4:0] shamt,
	output logic [mips_pkg::word_w-1:0] y
);

	logic lt_signed;
	logic lt_unsigned;

	assign lt_signed = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			mips_pkg::alu_add: y = a + b; // Wraps, no overflow trap
			mips_pkg::alu_sub: y = a - b;
			mips_pkg::alu_and: y = a & b;
			mips_pkg::alu_or: y = a | b;
			mips_pkg::alu_xor: y = a ^ b;
			mips_pkg::alu_slt: y = {{(mips_pkg::word_w-1){1'b0}}, lt_signed};
			mips_pkg::alu_sltu: y = {{(mips_pkg::word_w-1){1'b0}}, lt_unsigned};
			mips_pkg::alu_sll: y = a << shamt;
			mips_pkg::alu_srl: y = a >> shamt;
			mips_pkg::alu_lui: y = {b[15:0], 16'h0000};
			default: y = '0;
		endcase
	end

endmodule

//--- design/register_file.sv
/* 32 x 32 register file, two read ports, one write port, v0 tap */
`timescale 1ns/1ps

module register_file (
	input logic clk,
	input logic rst_n,
	input logic [mips_pkg::reg_addr_w-1:0] rs_addr,
	input logic [mips_pkg::reg_addr_w-1:0] rt_addr,
	input logic [mips_pkg::reg_addr_w-1:0] wr_addr,
	input logic wr_en,
	input logic [mips_pkg::word_w-1:0] wr_data,
	output logic [mips_pkg::word_w-1:0] rs_data,
	output logic [mips_pkg::word_w-1:0] rt_data,
	output logic [mips_pkg::word_w-1:0] v0
);

	logic [mips_pkg::word_w-1:0] regs [32];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data; // $zero never written
		end
	end

	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];
	assign v0 = regs[2];

endmodule

//--- design/control_decoder.sv
/* Instruction decoder producing the control struct */
`timescale 1ns/1ps

module control_decoder (
	input mips_pkg::instr_t instr,
	output mips_pkg::ctrl_t ctrl
);

	always_comb begin
		ctrl = '0; // Unknown encodings end up as a no-op
		ctrl.alu_op = mips_pkg::alu_add;
		ctrl.mem_kind = mips_pkg::mem_none;
		case (instr.op)
			mips_pkg::op_special: begin
				ctrl.dest_rd = 1'b1;
				ctrl.reg_write = 1'b1;
				case (instr.low.r.funct)
					mips_pkg::fn_addu: ctrl.alu_op = mips_pkg::alu_add;
					mips_pkg::fn_subu: ctrl.alu_op = mips_pkg::alu_sub;
					mips_pkg::fn_and: ctrl.alu_op = mips_pkg::alu_and;
					mips_pkg::fn_or: ctrl.alu_op = mips_pkg::alu_or;
					mips_pkg::fn_xor: ctrl.alu_op = mips_pkg::alu_xor;
					mips_pkg::fn_slt: ctrl.alu_op = mips_pkg::alu_slt;
					mips_pkg::fn_sltu: ctrl.alu_op = mips_pkg::alu_sltu;
					mips_pkg::fn_sll: begin
						ctrl.alu_op = mips_pkg::alu_sll;
						ctrl.shift_by_shamt = 1'b1;
					end
					mips_pkg::fn_srl: begin
						ctrl.alu_op = mips_pkg::alu_srl;
						ctrl.shift_by_shamt = 1'b1;
					end
					mips_pkg::fn_jr: begin
						ctrl.reg_write = 1'b0;
						ctrl.is_jr = 1'b1;
					end
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			mips_pkg::op_addiu, mips_pkg::op_slti,
			mips_pkg::op_andi, mips_pkg::op_ori,
			mips_pkg::op_xori, mips_pkg::op_lui: begin
				ctrl.src_b_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				case (instr.op)
					mips_pkg::op_slti: ctrl.alu_op = mips_pkg::alu_slt;
					mips_pkg::op_andi: ctrl.alu_op = mips_pkg::alu_and;
					mips_pkg::op_ori: ctrl.alu_op = mips_pkg::alu_or;
					mips_pkg::op_xori: ctrl.alu_op = mips_pkg::alu_xor;
					mips_pkg::op_lui: ctrl.alu_op = mips_pkg::alu_lui;
					default: ctrl.alu_op = mips_pkg::alu_add;
				endcase
				// Logical immediates are zero extended
				ctrl.imm_zero_extend = (instr.op == mips_pkg::op_andi) ||
					(instr.op == mips_pkg::op_ori) || (instr.op == mips_pkg::op_xori);
			end
			mips_pkg::op_lw, mips_pkg::op_lb, mips_pkg::op_lbu: begin
				ctrl.src_b_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				if (instr.op == mips_pkg::op_lw)
					ctrl.mem_kind = mips_pkg::mem_lw;
				else if (instr.op == mips_pkg::op_lb)
					ctrl.mem_kind = mips_pkg::mem_lb;
				else
					ctrl.mem_kind = mips_pkg::mem_lbu;
			end
			mips_pkg::op_sw: begin
				ctrl.src_b_imm = 1'b1;
				ctrl.mem_kind = mips_pkg::mem_sw;
			end
			mips_pkg::op_sb: begin
				ctrl.src_b_imm = 1'b1;
				ctrl.mem_kind = mips_pkg::mem_sb;
			end
			mips_pkg::op_beq: ctrl.is_beq = 1'b1;
			mips_pkg::op_bne: ctrl.is_bne = 1'b1;
			mips_pkg::op_j: ctrl.is_j = 1'b1;
			default: ;
		endcase
	end

endmodule

//--- design/fetch_unit.sv
/*
 * Program counter with delay-slot next counter,
 * branch compare, jump targets and halt detection
 */
`timescale 1ns/1ps

module fetch_unit (
	input logic clk,
	input logic rst_n,
	input mips_pkg::instr_t instr,
	input mips_pkg::ctrl_t ctrl,
	input logic [mips_pkg::word_w-1:0] rs_value,
	input logic [mips_pkg::word_w-1:0] rt_value,
	input logic step_done,
	output logic [mips_pkg::word_w-1:0] pc,
	output logic halted
);

	logic [mips_pkg::word_w-1:0] next_pc;
	logic [mips_pkg::word_w-1:0] pc_plus4;
	logic [mips_pkg::word_w-1:0] br_target;
	logic [mips_pkg::word_w-1:0] j_target;
	logic [mips_pkg::word_w-1:0] target;
	logic taken;

	assign pc_plus4 = pc + 32'd4;
	assign br_target = pc_plus4 + {{14{instr.low.imm[15]}}, instr.low.imm, 2'b00};
	assign j_target = {pc_plus4[31:28], instr.rs, instr.rt, instr.low.imm, 2'b00};

	assign taken = (ctrl.is_beq && (rs_value == rt_value)) ||
		(ctrl.is_bne && (rs_value != rt_value));

	always_comb begin
		if (ctrl.is_jr)
			target = rs_value;
		else if (ctrl.is_j)
			target = j_target;
		else if (taken)
			target = br_target;
		else
			target = next_pc + 32'd4; // Sequential after the delay slot
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= mips_pkg::reset_vector;
			next_pc <= mips_pkg::reset_vector + 32'd4;
			halted <= 1'b0;
		end else if (step_done) begin
			pc <= next_pc;
			next_pc <= target;
			if (next_pc == mips_pkg::halt_address)
				halted <= 1'b1; // Sticky until reset
		end
	end

endmodule

//--- design/mips_pkg.sv
/*
 * Core widths, reset vector, opcodes and function codes,
 * ALU and memory access enums, instruction/control/request structs
 */
package mips_pkg;

	localparam int word_w = 32;
	localparam int reg_addr_w = 5;

	localparam logic [word_w-1:0] reset_vector = 32'hBFC00000;
	localparam logic [word_w-1:0] halt_address = 32'h00000000;

	// Primary opcodes
	localparam logic [5:0] op_special = 6'h00;
	localparam logic [5:0] op_j = 6'h02;
	localparam logic [5:0] op_beq = 6'h04;
	localparam logic [5:0] op_bne = 6'h05;
	localparam logic [5:0] op_addiu = 6'h09;
	localparam logic [5:0] op_slti = 6'h0A;
	localparam logic [5:0] op_andi = 6'h0C;
	localparam logic [5:0] op_ori = 6'h0D;
	localparam logic [5:0] op_xori = 6'h0E;
	localparam logic [5:0] op_lui = 6'h0F;
	localparam logic [5:0] op_lb = 6'h20;
	localparam logic [5:0] op_lw = 6'h23;
	localparam logic [5:0] op_lbu = 6'h24;
	localparam logic [5:0] op_sb = 6'h28;
	localparam logic [5:0] op_sw = 6'h2B;

	// SPECIAL function codes
	localparam logic [5:0] fn_sll = 6'h00;
	localparam logic [5:0] fn_srl = 6'h02;
	localparam logic [5:0] fn_jr = 6'h08;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or = 6'h25;
	localparam logic [5:0] fn_xor = 6'h26;
	localparam logic [5:0] fn_slt = 6'h2A;
	localparam logic [5:0] fn_sltu = 6'h2B;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor,
		alu_slt, alu_sltu, alu_sll, alu_srl, alu_lui
	} alu_op_t;

	typedef enum logic [2:0] {
		mem_none, mem_lw, mem_lb, mem_lbu, mem_sw, mem_sb
	} mem_kind_t;

	typedef struct packed {
		logic [reg_addr_w-1:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fields_t;

	// Low half is either R fields or the immediate
	typedef union packed {
		r_fields_t r;
		logic [15:0] imm;
	} low_half_t;

	typedef struct packed {
		logic [5:0] op;
		logic [reg_addr_w-1:0] rs;
		logic [reg_addr_w-1:0] rt;
		low_half_t low;
	} instr_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic src_b_imm;
		logic imm_zero_extend;
		logic shift_by_shamt;
		logic dest_rd;
		logic reg_write;
		mem_kind_t mem_kind;
		logic is_beq;
		logic is_bne;
		logic is_j;
		logic is_jr;
	} ctrl_t;

	typedef struct packed {
		logic [word_w-1:0] addr;
		logic [word_w-1:0] wdata;
		mem_kind_t mem_kind;
	} mem_req_t;

endpackage
